/* logic/rb_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Ring buffer sizes, cycle operation and status state encodings.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package rb_pkg;

	// Word width and number of slots.
	localparam int DATA_W = 8;
	localparam int DEPTH  = 8;

	// What happened to the pointers in one cycle.
	typedef enum logic [1:0] {
		OP_NONE = 2'b00,
		OP_PUSH = 2'b01,
		OP_POP  = 2'b10,
		OP_BOTH = 2'b11
	} op_e;

	// Last operation that moved only one pointer.
	typedef enum logic {
		LAST_POP  = 1'b0,
		LAST_PUSH = 1'b1
	} lastop_e;

endpackage

/* logic/rb_write_ctrl.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Write side: one-hot tail ring, write acceptance, slot write enables.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module rb_write_ctrl (
	input  logic                     i_clk,
	input  logic                     i_srst,
	input  logic                     i_we,
	input  logic                     i_full,
	output logic [rb_pkg::DEPTH-1:0] o_tail_oh,
	output logic [rb_pkg::DEPTH-1:0] o_slot_we,
	output logic                     o_push
);
	import rb_pkg::*;

	logic [DEPTH-1:0] tail;
	logic             push;

	// A write on full is dropped.
	assign push = i_we & ~i_full;

	// Tail starts at slot 0 and rotates up on each accepted write.
	always_ff @(posedge i_clk) begin
		if (i_srst) begin
			tail <= DEPTH'(1);
		end else if (push) begin
			tail <= {tail[DEPTH-2:0], tail[DEPTH-1]};
		end
	end

	// Only the slot under the tail is loaded.
	assign o_slot_we = tail & {DEPTH{push}};

	assign o_tail_oh = tail;
	assign o_push    = push;

endmodule

/* logic/rb_slot.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One storage word with clear, load and gated read-out.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module rb_slot (
	input  logic                      i_clk,
	input  logic                      i_srst,
	input  logic                      i_we,
	input  logic                      i_clr,
	input  logic                      i_sel,
	input  logic [rb_pkg::DATA_W-1:0] i_d,
	output logic [rb_pkg::DATA_W-1:0] o_q
);
	import rb_pkg::*;

	logic [DATA_W-1:0] data;

	// Clear has priority over a load.
	always_ff @(posedge i_clk) begin
		if (i_srst || i_clr) begin
			data <= '0;
		end else if (i_we) begin
			data <= i_d;
		end
	end

	// Zero when not selected so that the slots can be ORed.
	assign o_q = i_sel ? data : '0;

endmodule

/* logic/rb_read_ctrl.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Read side: one-hot head ring, read acceptance, slot clears and
// the OR of all gated slot words.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module rb_read_ctrl (
	input  logic                                          i_clk,
	input  logic                                          i_srst,
	input  logic                                          i_re,
	input  logic                                          i_empty,
	input  logic [rb_pkg::DEPTH-1:0][rb_pkg::DATA_W-1:0] i_slot_q,
	output logic [rb_pkg::DEPTH-1:0]                      o_head_oh,
	output logic [rb_pkg::DEPTH-1:0]                      o_slot_clr,
	output logic                                          o_pop,
	output logic [rb_pkg::DATA_W-1:0]                     o_rdata
);
	import rb_pkg::*;

	logic [DEPTH-1:0]  head;
	logic              pop;
	logic [DATA_W-1:0] rdata_or;

	// A read on empty is dropped.
	assign pop = i_re & ~i_empty;

	// Head starts at slot 0 and follows the tail around the ring.
	always_ff @(posedge i_clk) begin
		if (i_srst) begin
			head <= DEPTH'(1);
		end else if (pop) begin
			head <= {head[DEPTH-2:0], head[DEPTH-1]};
		end
	end

	// The popped slot is zeroed on the same edge.
	assign o_slot_clr = head & {DEPTH{pop}};

	// Only the head slot drives a nonzero word.
	always_comb begin
		rdata_or = '0;
		for (int i = 0; i < DEPTH; i++) begin
			rdata_or = rdata_or | i_slot_q[i];
		end
	end

	assign o_head_oh = head;
	assign o_pop     = pop;
	assign o_rdata   = rdata_or;

endmodule

/* logic/rb_status.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Status: last-operation register, empty and full flags.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module rb_status (
	input  logic                     i_clk,
	input  logic                     i_srst,
	input  logic                     i_push,
	input  logic                     i_pop,
	input  logic [rb_pkg::DEPTH-1:0] i_head_oh,
	input  logic [rb_pkg::DEPTH-1:0] i_tail_oh,
	output logic                     o_empty,
	output logic                     o_full
);
	import rb_pkg::*;

	op_e     cur_op;
	lastop_e last_op;
	logic    meet;

	// Classify the cycle.
	always_comb begin
		case ({i_pop, i_push})
			2'b01:   cur_op = OP_PUSH;
			2'b10:   cur_op = OP_POP;
			2'b11:   cur_op = OP_BOTH;
			default: cur_op = OP_NONE;
		endcase
	end

	// Only a lone push or a lone pop changes the distance between pointers.
	always_ff @(posedge i_clk) begin
		if (i_srst) begin
			last_op <= LAST_POP;
		end else begin
			case (cur_op)
				OP_PUSH: last_op <= LAST_PUSH;
				OP_POP:  last_op <= LAST_POP;
				default: last_op <= last_op;
			endcase
		end
	end

	// Pointers at the same slot.
	assign meet = |(i_head_oh & i_tail_oh);

	assign o_empty = meet & (last_op == LAST_POP);
	assign o_full  = meet & (last_op == LAST_PUSH);

endmodule

/* logic/ring_buffer.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Ring buffer top: write and read controllers, status block and
// the array of storage slots.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module ring_buffer (
	input  logic                      i_clk,
	input  logic                      i_srst,
	input  logic                      i_we,
	input  logic                      i_re,
	input  logic [rb_pkg::DATA_W-1:0] i_wdata,
	output logic [rb_pkg::DATA_W-1:0] o_rdata,
	output logic                      o_empty,
	output logic                      o_full
);
	import rb_pkg::*;

	// Pointers and per-slot strobes.
	logic [DEPTH-1:0] tail_oh;
	logic [DEPTH-1:0] slot_we;
	logic             push;
	logic [DEPTH-1:0] head_oh;
	logic [DEPTH-1:0] slot_clr;
	logic             pop;

	// Gated slot words, at most one nonzero.
	logic [DEPTH-1:0][DATA_W-1:0] slot_q;

	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Controllers.
	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	rb_write_ctrl u_write_ctrl (
		.i_clk     (i_clk),
		.i_srst    (i_srst),
		.i_we      (i_we),
		.i_full    (o_full),
		.o_tail_oh (tail_oh),
		.o_slot_we (slot_we),
		.o_push    (push)
	);

	rb_read_ctrl u_read_ctrl (
		.i_clk      (i_clk),
		.i_srst     (i_srst),
		.i_re       (i_re),
		.i_empty    (o_empty),
		.i_slot_q   (slot_q),
		.o_head_oh  (head_oh),
		.o_slot_clr (slot_clr),
		.o_pop      (pop),
		.o_rdata    (o_rdata)
	);

	rb_status u_status (
		.i_clk     (i_clk),
		.i_srst    (i_srst),
		.i_push    (push),
		.i_pop     (pop),
		.i_head_oh (head_oh),
		.i_tail_oh (tail_oh),
		.o_empty   (o_empty),
		.o_full    (o_full)
	);

	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Storage slots.
	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	for (genvar i = 0; i < DEPTH; i++) begin : g_slot
		rb_slot u_slot (
			.i_clk  (i_clk),
			.i_srst (i_srst),
			.i_we   (slot_we[i]),
			.i_clr  (slot_clr[i]),
			.i_sel  (head_oh[i]),
			.i_d    (i_wdata),
			.o_q    (slot_q[i])
		);
	end

endmodule

/* tests/ring_buffer_assertions.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Concurrent assertions on ring buffer flags and pointers.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module ring_buffer_assertions (
	input logic                     i_clk,
	input logic                     i_srst,
	input logic                     i_empty,
	input logic                     i_full,
	input logic [rb_pkg::DEPTH-1:0] i_head_oh,
	input logic [rb_pkg::DEPTH-1:0] i_tail_oh
);
	import rb_pkg::*;

	// The two flags exclude each other.
	flags_exclusive: assert property (@(posedge i_clk) disable iff (i_srst)
		!(i_empty && i_full))
		else $error("empty and full are both high");

	// Each pointer marks exactly one slot.
	pointers_onehot: assert property (@(posedge i_clk) disable iff (i_srst)
		$onehot(i_head_oh) && $onehot(i_tail_oh))
		else $error("head or tail pointer is not one-hot");

	// Empty or full only when head and tail meet.
	flags_need_meet: assert property (@(posedge i_clk) disable iff (i_srst)
		(i_empty || i_full) |-> (i_head_oh == i_tail_oh))
		else $error("flag raised while head and tail differ");

endmodule

/* tests/ring_buffer_tb.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Ring buffer testbench: vector playback, random phase against a
// queue model, watchdog and verdict.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module ring_buffer_tb;
	import rb_pkg::*;

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 3;
	localparam int RAND_CYCLES  = 300;
	localparam int MAX_VEC      = 64;
	localparam int COLS         = 6;

	logic              i_clk;
	logic              i_srst;
	logic              i_we;
	logic              i_re;
	logic [DATA_W-1:0] i_wdata;
	logic [DATA_W-1:0] o_rdata;
	logic              o_empty;
	logic              o_full;

	logic [7:0]        vec_mem [0:MAX_VEC*COLS-1];
	int                n_vec;
	logic              vec_ready;
	logic [DATA_W-1:0] model_q[$];

	ring_buffer u_dut (
		.i_clk   (i_clk),
		.i_srst  (i_srst),
		.i_we    (i_we),
		.i_re    (i_re),
		.i_wdata (i_wdata),
		.o_rdata (o_rdata),
		.o_empty (o_empty),
		.o_full  (o_full)
	);

	bind ring_buffer ring_buffer_assertions u_assertions (
		.i_clk     (i_clk),
		.i_srst    (i_srst),
		.i_empty   (o_empty),
		.i_full    (o_full),
		.i_head_oh (head_oh),
		.i_tail_oh (tail_oh)
	);

	always #(CLK_PERIOD / 2) i_clk = ~i_clk;

	task automatic check(input string name, input logic [7:0] exp_val,
			input logic [7:0] act_val);
		if (exp_val !== act_val) begin
			$display("MISMATCH %s expected %0h actual %0h", name, exp_val, act_val);
			$display("Test FAILED");
			$fatal(1, "check failed");
		end
	endtask

	// Compares all three outputs with their expected values.
	task automatic check_outputs(input string tag, input logic [7:0] exp_rdata,
			input logic exp_empty, input logic exp_full);
		check({tag, " rdata"}, exp_rdata, o_rdata);
		check({tag, " empty"}, 8'(exp_empty), 8'(o_empty));
		check({tag, " full"}, 8'(exp_full), 8'(o_full));
	endtask

	// Applies the acceptance rules of one cycle to the queue model.
	task automatic model_step(input logic we, input logic re, input logic [7:0] wdata);
		logic was_full;
		logic was_empty;
		was_full  = (model_q.size() == DEPTH);
		was_empty = (model_q.size() == 0);
		if (re && !was_empty) begin
			void'(model_q.pop_front());
		end
		if (we && !was_full) begin
			model_q.push_back(wdata);
		end
	endtask

	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Watchdog.
	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		int limit;
		wait (vec_ready === 1'b1);
		// Twice the expected run length.
		limit = (n_vec + RAND_CYCLES + RESET_CYCLES + 4) * CLK_PERIOD * 2;
		#(limit);
		$display("Timeout: the ring buffer test did not finish in time");
		$display("Test FAILED");
		$fatal(1, "watchdog expired");
	end

	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus and checks.
	//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		logic [31:0] rnd;
		int          base;
		logic        bias_write;
		logic        exp_empty;
		logic [7:0]  exp_rdata;
		rnd       = $urandom(76);
		i_clk     = 1'b0;
		i_srst    = 1'b1;
		i_we      = 1'b0;
		i_re      = 1'b0;
		i_wdata   = '0;
		vec_ready = 1'b0;
		n_vec     = 0;

		// Unused entries keep 0xff, which marks the end of the vectors.
		for (int i = 0; i < MAX_VEC * COLS; i++) begin
			vec_mem[i] = 8'hff;
		end
		$readmemh("tests/ring_buffer_vectors.txt", vec_mem);
		while (n_vec < MAX_VEC && vec_mem[n_vec * COLS] != 8'hff) begin
			n_vec++;
		end
		vec_ready = 1'b1;

		repeat (RESET_CYCLES) @(posedge i_clk);
		@(negedge i_clk);
		i_srst = 1'b0;
		check_outputs("reset", 8'h00, 1'b1, 1'b0);

		// Directed vectors, each checked after its own edge.
		for (int v = 0; v < n_vec; v++) begin
			base    = v * COLS;
			i_we    = vec_mem[base][0];
			i_re    = vec_mem[base + 1][0];
			i_wdata = vec_mem[base + 2];
			@(negedge i_clk);
			check_outputs($sformatf("vector %0d", v), vec_mem[base + 3],
				vec_mem[base + 4][0], vec_mem[base + 5][0]);
		end

		// Random phase; the write bias flips every 50 cycles.
		for (int c = 0; c < RAND_CYCLES; c++) begin
			rnd        = $urandom;
			bias_write = ((c / 50) % 2) == 0;
			i_we       = bias_write ? (rnd[1:0] != 2'b00) : (rnd[1:0] == 2'b00);
			i_re       = bias_write ? (rnd[3:2] == 2'b00) : (rnd[3:2] != 2'b00);
			i_wdata    = rnd[15:8];
			@(negedge i_clk);
			model_step(i_we, i_re, i_wdata);
			exp_empty = (model_q.size() == 0);
			exp_rdata = exp_empty ? 8'h00 : model_q[0];
			check_outputs($sformatf("random %0d", c), exp_rdata, exp_empty,
				model_q.size() == DEPTH);
		end

		i_we = 1'b0;
		i_re = 1'b0;
		$display("Test OK");
		$finish;
	end

endmodule

/* tests/ring_buffer_vectors.txt */
// Columns in hex: we re wdata exp_rdata exp_empty exp_full
// The expected columns hold after the clock edge of the same line.
0 0 00 00 1 0
1 0 11 11 0 0
1 0 22 11 0 0
1 0 33 11 0 0
0 1 00 22 0 0
0 1 00 33 0 0
0 1 00 00 1 0
// Reads on empty are dropped.
0 1 00 00 1 0
0 1 00 00 1 0
1 0 44 44 0 0
0 1 00 00 1 0
// Fill to full, then a dropped write.
1 0 a0 a0 0 0
1 0 a1 a0 0 0
1 0 a2 a0 0 0
1 0 a3 a0 0 0
1 0 a4 a0 0 0
1 0 a5 a0 0 0
1 0 a6 a0 0 0
1 0 a7 a0 0 1
1 0 ee a0 0 1
// Write and read on full: only the read is accepted.
1 1 ef a1 0 0
1 0 a8 a1 0 1
0 1 00 a2 0 0
0 1 00 a3 0 0
// Write and read on a partly filled buffer across the wrap.
1 1 b0 a4 0 0
1 1 b1 a5 0 0
1 1 b2 a6 0 0
1 1 b3 a7 0 0
0 1 00 a8 0 0
0 1 00 b0 0 0
0 1 00 b1 0 0
0 1 00 b2 0 0
0 1 00 b3 0 0
0 1 00 00 1 0
// Write and read on empty: only the write is accepted.
1 1 c0 c0 0 0
1 1 c1 c1 0 0
0 1 00 00 1 0
0 0 00 00 1 0

/* all.f */
logic/rb_pkg.sv
logic/rb_write_ctrl.sv
logic/rb_slot.sv
logic/rb_read_ctrl.sv
logic/rb_status.sv
logic/ring_buffer.sv
tests/ring_buffer_assertions.sv
tests/ring_buffer_tb.sv

/* Makefile */
# Verilator build and run of the ring buffer testbench.

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --assert -f all.f --top-module ring_buffer_tb -Mdir obj_dir -o ring_buffer_sim
	./obj_dir/ring_buffer_sim > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "Test OK" $(LOG); then echo "Simulation ended without a verdict"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
